// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= tb_dma
RTL_TOP    ?= dma_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= All checks passed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
verilog/dma_pkg.sv
verilog/dma_req_sync.sv
verilog/dma_apb_regs.sv
verilog/dma_ahb_mover.sv
verilog/dma_top.sv
verif/tb_ahb_mem.sv
verif/tb_dma.sv

// ==== verif/tb_ahb_mem.sv ====
// Behavioral AHB-Lite slave memory with random wait states and an error region
`timescale 1ns/1ns

module tb_ahb_mem #(
    parameter int          DEPTH    = 1024,              // Words
    parameter logic [31:0] ERR_BASE = 32'h0000_8000,
    parameter logic [31:0] ERR_SIZE = 32'h0000_0100      // Bytes
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        stall_en,    // Random wait states when high
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      mem [DEPTH];
    logic             dp_vld;       // Data phase in progress
    logic             dp_write;
    logic             dp_err;
    logic [IDX_W-1:0] dp_idx;
    logic [1:0]       wait_cnt;
    logic             err_first;    // First cycle of the two-cycle error
    logic             addr_err;

    assign addr_err = (haddr >= ERR_BASE) && (haddr < ERR_BASE + ERR_SIZE);
    assign hready   = (wait_cnt == 2'd0) && !err_first;
    assign hresp    = dp_vld && dp_err;
    assign hrdata   = (dp_vld && !dp_write && !dp_err) ? mem[dp_idx] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dp_vld    <= 1'b0;
            dp_write  <= 1'b0;
            dp_err    <= 1'b0;
            dp_idx    <= '0;
            wait_cnt  <= 2'd0;
            err_first <= 1'b0;
        end else begin
            err_first <= 1'b0;
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end
            // Address phase accepted
            if (hready) begin
                dp_vld    <= htrans[1];
                dp_write  <= hwrite;
                dp_err    <= addr_err;
                dp_idx    <= haddr[IDX_W+1:2];
                err_first <= htrans[1] && addr_err;
                wait_cnt  <= (htrans[1] && stall_en && !addr_err) ? 2'($urandom % 4) : 2'd0;
            end
        end
    end

    // Write lands at the end of its data phase
    always @(posedge clk) begin
        if (dp_vld && hready && dp_write && !dp_err) begin
            mem[dp_idx] <= hwdata;
        end
    end

endmodule

// ==== verif/tb_dma.sv ====
// DMA controller testbench with APB driver, reference copy model and timeout
`timescale 1ns/1ns

module tb_dma;
    import dma_pkg::*;

    localparam int          MEM_DEPTH   = 1024;             // Words
    localparam logic [31:0] ERR_BASE    = 32'h0000_8000;
    localparam logic [31:0] SEED        = 32'hf9d6_a0b9;
    localparam int          MAX_LEN     = 32;
    localparam int          TIMEOUT_CYC = (5 * MAX_LEN + 4) * 40 + 2000;  // Words in tests 2 to 6

    logic              clk = 1'b0;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    cfg_addr_t         paddr;
    data_t             pwdata;
    data_t             prdata;
    logic              pready;
    logic              pslverr;
    addr_t             haddr;
    logic [1:0]        htrans;
    logic              hwrite;
    data_t             hwdata;
    data_t             hrdata;
    logic              hready;
    logic              hresp;
    logic [CH_NUM-1:0] dma_req;
    logic [CH_NUM-1:0] dma_done;
    logic              dma_err;
    logic              stall_en;
    data_t             shadow [MEM_DEPTH];   // Expected memory
    int                cycle_cnt = 0;
    int                err_cnt = 0;

    always #4 clk = ~clk;

    dma_top u_dut (.*);

    tb_ahb_mem #(.DEPTH(MEM_DEPTH), .ERR_BASE(ERR_BASE)) u_mem (.*);

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    // Helpers --------------------
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, msg, got, exp);
            $display("Checks failed");
            $fatal(1, "Mismatch ends the run");
        end
    endtask

    // Starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input cfg_addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;                                 // Access phase outputs settled
        check_eq(32'(pready), 32'd1, "pready in access phase");
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input cfg_addr_t addr, input data_t wdata, input logic exp_err);
        data_t rdata;
        logic  err;
        apb_xfer(1'b1, addr, wdata, rdata, err);
        check_eq(32'(err), 32'(exp_err), $sformatf("pslverr on write to 0x%02h", addr));
    endtask

    task automatic apb_read(input cfg_addr_t addr, input data_t exp, input logic exp_err);
        data_t rdata;
        logic  err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_eq(32'(err), 32'(exp_err), $sformatf("pslverr on read of 0x%02h", addr));
        check_eq(rdata, exp, $sformatf("read of 0x%02h", addr));
    endtask

    function automatic cfg_addr_t reg_addr(input int ch, input cfg_addr_t off);
        return cfg_addr_t'(ch * int'(CH_STRIDE)) + off;
    endfunction

    function automatic data_t ctrl_word(input logic start, input logic trig);
        data_t w;
        w = '0;
        w[CTRL_START_BIT] = start;
        w[CTRL_TRIG_BIT]  = trig;
        return w;
    endfunction

    function automatic data_t stat_word(input logic [CH_NUM-1:0] done,
                                        input logic [CH_NUM-1:0] err,
                                        input logic [CH_NUM-1:0] busy);
        data_t w;
        w = '0;
        w[STAT_DONE_LSB +: CH_NUM] = done;
        w[STAT_ERR_LSB +: CH_NUM]  = err;
        w[STAT_BUSY_LSB +: CH_NUM] = busy;
        return w;
    endfunction

    task automatic config_ch(input int ch, input addr_t src, input addr_t dst, input int len);
        apb_write(reg_addr(ch, REG_SRC), src, 1'b0);
        apb_write(reg_addr(ch, REG_DST), dst, 1'b0);
        apb_write(reg_addr(ch, REG_LEN), data_t'(len), 1'b0);
    endtask

    task automatic wait_done(input int ch);
        while (dma_done[ch] !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // Word copy from source to destination; an error leaves the destination alone
    function automatic void ref_copy(input addr_t src, input addr_t dst, input int len,
                                     input logic err);
        int s;
        int d;
        s = int'(src >> 2) % MEM_DEPTH;
        d = int'(dst >> 2) % MEM_DEPTH;
        if (err) begin
            return;
        end
        for (int i = 0; i < len; i++) begin
            shadow[(d + i) % MEM_DEPTH] = shadow[(s + i) % MEM_DEPTH];
        end
    endfunction

    task automatic compare_mem(input string what);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            check_eq(u_mem.mem[i], shadow[i], $sformatf("%s, memory word %0d", what, i));
        end
    endtask

    // Tests --------------------
    initial begin
        data_t seed_ret;
        int    len0;
        int    len1;

        seed_ret = $urandom(SEED);
        arst_n   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        dma_req  = '0;
        stall_en = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i]     = $urandom;
            u_mem.mem[i]  = shadow[i];
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        // Register access, unmapped addresses, zero count start
        for (int c = 0; c < CH_NUM; c++) begin
            config_ch(c, 32'h1234_5670 ^ data_t'(c << 8), 32'hABCD_EF00 ^ data_t'(c << 8),
                      32'h00A5 + c);
            apb_write(reg_addr(c, REG_CTRL), ctrl_word(1'b0, 1'b1), 1'b0);
            apb_read(reg_addr(c, REG_SRC), 32'h1234_5670 ^ data_t'(c << 8), 1'b0);
            apb_read(reg_addr(c, REG_DST), 32'hABCD_EF00 ^ data_t'(c << 8), 1'b0);
            apb_read(reg_addr(c, REG_LEN), data_t'(32'h00A5 + c), 1'b0);
            apb_read(reg_addr(c, REG_CTRL), ctrl_word(1'b0, 1'b1), 1'b0);
        end
        apb_read(REG_STATUS, '0, 1'b0);
        apb_read(8'h24, '0, 1'b1);
        apb_read(8'h48, '0, 1'b1);
        apb_write(8'h38, 32'hFFFF_FFFF, 1'b1);
        apb_write(reg_addr(1, REG_LEN), '0, 1'b0);
        apb_write(reg_addr(1, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b1);

        // Software started copy on channel 0
        len0 = 1 + int'($urandom % MAX_LEN);
        config_ch(0, 32'h000, 32'h100, len0);
        apb_write(reg_addr(0, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b0);
        wait_done(0);
        ref_copy(32'h000, 32'h100, len0, 1'b0);
        compare_mem("software copy");
        apb_write(REG_STATUS, stat_word(2'b01, 2'b00, 2'b00), 1'b0);
        check_eq(32'(dma_done), 32'd0, "dma_done after clear");

        // Trigger mode on channel 1
        len1 = 1 + int'($urandom % MAX_LEN);
        config_ch(1, 32'h200, 32'h300, len1);
        apb_write(reg_addr(1, REG_CTRL), ctrl_word(1'b1, 1'b1), 1'b0);
        repeat (200) @(negedge clk);
        apb_read(REG_STATUS, stat_word(2'b00, 2'b00, 2'b10), 1'b0);
        compare_mem("waiting for trigger");
        dma_req[1] = 1'b1;
        repeat (2) @(negedge clk);
        dma_req[1] = 1'b0;
        wait_done(1);
        ref_copy(32'h200, 32'h300, len1, 1'b0);
        compare_mem("triggered copy");
        apb_write(REG_STATUS, stat_word(2'b10, 2'b00, 2'b00), 1'b0);

        // Both channels with wait states
        stall_en = 1'b1;
        len0 = 1 + int'($urandom % MAX_LEN);
        len1 = 1 + int'($urandom % MAX_LEN);
        config_ch(0, 32'h400, 32'h500, len0);
        config_ch(1, 32'h600, 32'h700, len1);
        apb_write(reg_addr(0, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b0);
        apb_write(reg_addr(1, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b0);
        wait_done(0);
        wait_done(1);
        ref_copy(32'h400, 32'h500, len0, 1'b0);
        ref_copy(32'h600, 32'h700, len1, 1'b0);
        compare_mem("two channel copy");
        apb_write(REG_STATUS, stat_word(2'b11, 2'b00, 2'b00), 1'b0);

        // Error response from the source
        config_ch(0, ERR_BASE, 32'h800, 4);
        apb_write(reg_addr(0, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b0);
        while (dma_err !== 1'b1) begin
            @(negedge clk);
        end
        apb_read(REG_STATUS, stat_word(2'b00, 2'b01, 2'b00), 1'b0);
        check_eq(32'(dma_done), 32'd0, "dma_done after error");
        ref_copy(ERR_BASE, 32'h800, 4, 1'b1);
        compare_mem("error response");
        apb_write(REG_STATUS, stat_word(2'b00, 2'b01, 2'b00), 1'b0);
        check_eq(32'(dma_err), 32'd0, "dma_err after clear");

        // Control write to a busy channel
        config_ch(1, 32'h900, 32'hA00, MAX_LEN);
        apb_write(reg_addr(1, REG_CTRL), ctrl_word(1'b1, 1'b0), 1'b0);
        apb_write(reg_addr(1, REG_CTRL), ctrl_word(1'b0, 1'b1), 1'b1);
        wait_done(1);
        ref_copy(32'h900, 32'hA00, MAX_LEN, 1'b0);
        compare_mem("copy after rejected write");
        apb_read(REG_STATUS, stat_word(2'b10, 2'b00, 2'b00), 1'b0);

        if (err_cnt == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "Errors were reported");
        end
    end

endmodule

// ==== verilog/dma_ahb_mover.sv ====
// DMA round-robin channel arbiter and AHB-Lite read-then-write word copy engine
`timescale 1ns/1ns

module dma_ahb_mover (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [dma_pkg::CH_NUM-1:0]   ch_run,
    input  dma_pkg::addr_t               ch_src [dma_pkg::CH_NUM],
    input  dma_pkg::addr_t               ch_dst [dma_pkg::CH_NUM],
    input  dma_pkg::len_t                ch_len [dma_pkg::CH_NUM],
    output logic [dma_pkg::CH_NUM-1:0]   ch_start,
    output logic [dma_pkg::CH_NUM-1:0]   ch_end,
    output logic                         end_err,
    output dma_pkg::addr_t               haddr,
    output logic [1:0]                   htrans,
    output logic                         hwrite,
    output dma_pkg::data_t               hwdata,
    input  dma_pkg::data_t               hrdata,
    input  logic                         hready,
    input  logic                         hresp
);
    import dma_pkg::*;

    // S_RDATA carries the write address phase, S_WDATA the next read address
    enum logic [1:0] {S_IDLE, S_RADDR, S_RDATA, S_WDATA} state;

    logic [CH_IDX_W-1:0] cur_idx;      // Channel owning the bus, or last owner
    logic [CH_IDX_W-1:0] pick_idx;
    logic                pick_vld;
    logic                grant;
    logic                data_phase;
    logic                more;         // Words left after the current one
    addr_t               rd_addr;      // Next source address
    addr_t               wr_addr;      // Next destination address
    len_t                words_left;

    // Round robin --------------------
    // Search starts one past the last granted channel
    always_comb begin
        pick_vld = 1'b0;
        pick_idx = cur_idx;
        for (int i = 1; i <= CH_NUM; i++) begin
            if (!pick_vld && ch_run[(int'(cur_idx) + i) % CH_NUM]) begin
                pick_vld = 1'b1;
                pick_idx = CH_IDX_W'((int'(cur_idx) + i) % CH_NUM);
            end
        end
    end

    assign grant      = (state == S_IDLE) && pick_vld;
    assign data_phase = (state == S_RDATA) || (state == S_WDATA);
    assign more       = words_left > len_t'(1);

    // Control FSM --------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            cur_idx    <= CH_IDX_W'(CH_NUM - 1);
            ch_start   <= '0;
            ch_end     <= '0;
            end_err    <= 1'b0;
            haddr      <= '0;
            htrans     <= HTRANS_IDLE;
            hwrite     <= 1'b0;
            words_left <= '0;
        end else begin
            ch_start <= '0;
            ch_end   <= '0;
            end_err  <= 1'b0;
            if (data_phase && hresp) begin
                htrans <= HTRANS_IDLE;             // Cancel the queued transfer
                if (hready) begin
                    ch_end[cur_idx] <= 1'b1;
                    end_err         <= 1'b1;
                    state           <= S_IDLE;
                end
            end else begin
                case (state)
                    S_IDLE: begin
                        if (pick_vld) begin
                            cur_idx           <= pick_idx;
                            ch_start[pick_idx] <= 1'b1;
                            haddr             <= ch_src[pick_idx];
                            htrans            <= HTRANS_NONSEQ;
                            hwrite            <= 1'b0;
                            words_left        <= ch_len[pick_idx];
                            state             <= S_RADDR;
                        end
                    end
                    S_RADDR: begin
                        if (hready) begin
                            haddr  <= wr_addr;     // Write address rides the read data phase
                            hwrite <= 1'b1;
                            state  <= S_RDATA;
                        end
                    end
                    S_RDATA: begin
                        if (hready) begin
                            if (more) begin
                                haddr  <= rd_addr;
                                hwrite <= 1'b0;
                            end else begin
                                htrans <= HTRANS_IDLE;
                            end
                            state <= S_WDATA;
                        end
                    end
                    default: begin
                        if (hready) begin
                            words_left <= words_left - len_t'(1);
                            if (more) begin
                                haddr  <= wr_addr;
                                hwrite <= 1'b1;
                                htrans <= HTRANS_NONSEQ;
                                state  <= S_RDATA;
                            end else begin
                                htrans          <= HTRANS_IDLE;
                                ch_end[cur_idx] <= 1'b1;
                                state           <= S_IDLE;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // Address and data path --------------------
    always_ff @(posedge clk) begin
        if (grant) begin
            rd_addr <= ch_src[pick_idx] + ADDR_W'(4);
            wr_addr <= ch_dst[pick_idx];
        end else if (state == S_RDATA && hready && !hresp) begin
            hwdata  <= hrdata;                     // Held through the write data phase
            wr_addr <= wr_addr + ADDR_W'(4);
            if (more) begin
                rd_addr <= rd_addr + ADDR_W'(4);
            end
        end
    end

    // Checks --------------------
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (htrans == HTRANS_NONSEQ && !hready && !hresp)
            |=> ($stable(haddr) && $stable(htrans)));

    // Register file keeps the channel addresses word aligned
    a_align: assert property (@(posedge clk) disable iff (!arst_n)
        (htrans == HTRANS_NONSEQ) |-> (haddr[1:0] == 2'b00));

endmodule

// ==== verilog/dma_apb_regs.sv ====
// DMA APB register file with channel run control, status and done/error outputs
`timescale 1ns/1ns

module dma_apb_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  dma_pkg::cfg_addr_t           paddr,
    input  dma_pkg::data_t               pwdata,
    output dma_pkg::data_t               prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic [dma_pkg::CH_NUM-1:0]   req_pending,
    input  logic [dma_pkg::CH_NUM-1:0]   ch_start,
    input  logic [dma_pkg::CH_NUM-1:0]   ch_end,
    input  logic                         end_err,
    output logic [dma_pkg::CH_NUM-1:0]   ch_run,
    output dma_pkg::addr_t               ch_src [dma_pkg::CH_NUM],
    output dma_pkg::addr_t               ch_dst [dma_pkg::CH_NUM],
    output dma_pkg::len_t                ch_len [dma_pkg::CH_NUM],
    output logic [dma_pkg::CH_NUM-1:0]   dma_done,
    output logic                         dma_err
);
    import dma_pkg::*;

    addr_t             src_q [CH_NUM];
    addr_t             dst_q [CH_NUM];
    len_t              len_q [CH_NUM];
    logic [CH_NUM-1:0] start_q;
    logic [CH_NUM-1:0] trig_q;    // Wait for DMA_REQ
    logic [CH_NUM-1:0] busy_q;
    logic [CH_NUM-1:0] done_q;
    logic [CH_NUM-1:0] err_q;
    logic [CH_NUM-1:0] done_clr;
    logic [CH_NUM-1:0] err_clr;

    cfg_addr_t           blk;
    cfg_addr_t           off;
    logic [CH_IDX_W-1:0] ch_idx;
    logic                ch_hit;
    logic                reg_hit;
    logic                stat_hit;
    logic                apb_acc;
    logic                ctrl_wr;
    logic                wr_ok;
    data_t               rd_word;

    // Address decode --------------------
    assign apb_acc  = psel & penable;                  // Access phase
    assign blk      = paddr / CH_STRIDE;
    assign off      = paddr % CH_STRIDE;
    assign ch_idx   = blk[CH_IDX_W-1:0];
    assign ch_hit   = blk < cfg_addr_t'(CH_NUM);
    assign stat_hit = paddr == REG_STATUS;

    always_comb begin
        reg_hit = 1'b0;
        if (ch_hit) begin
            case (off)
                REG_SRC, REG_DST, REG_LEN, REG_CTRL: reg_hit = 1'b1;
                default:                            reg_hit = 1'b0;
            endcase
        end
    end

    // Unmapped, control write while busy, or start with nothing to move
    assign ctrl_wr = apb_acc & pwrite & reg_hit & (off == REG_CTRL);
    assign pslverr = apb_acc & (~(reg_hit | stat_hit)
                              | (ctrl_wr & busy_q[ch_idx])
                              | (ctrl_wr & pwdata[CTRL_START_BIT] & (len_q[ch_idx] == '0)));
    assign wr_ok   = apb_acc & pwrite & ~pslverr;
    assign pready  = 1'b1;                             // Zero wait states

    // Read mux --------------------
    always_comb begin
        rd_word = '0;
        if (stat_hit) begin
            for (int c = 0; c < CH_NUM; c++) begin
                rd_word[STAT_DONE_LSB + c] = done_q[c];
                rd_word[STAT_ERR_LSB + c]  = err_q[c];
                rd_word[STAT_BUSY_LSB + c] = busy_q[c];
            end
        end else if (reg_hit) begin
            case (off)
                REG_SRC: rd_word = src_q[ch_idx];
                REG_DST: rd_word = dst_q[ch_idx];
                REG_LEN: rd_word = data_t'(len_q[ch_idx]);
                default: begin
                    rd_word[CTRL_START_BIT] = start_q[ch_idx];
                    rd_word[CTRL_TRIG_BIT]  = trig_q[ch_idx];
                end
            endcase
        end
    end

    assign prdata = (apb_acc && !pwrite && !pslverr) ? rd_word : '0;

    // Register updates --------------------
    assign done_clr = (wr_ok && stat_hit) ? pwdata[STAT_DONE_LSB +: CH_NUM] : '0;
    assign err_clr  = (wr_ok && stat_hit) ? pwdata[STAT_ERR_LSB +: CH_NUM] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < CH_NUM; c++) begin
                src_q[c] <= '0;
                dst_q[c] <= '0;
                len_q[c] <= '0;
            end
            start_q <= '0;
            trig_q  <= '0;
            busy_q  <= '0;
            done_q  <= '0;
            err_q   <= '0;
        end else begin
            for (int c = 0; c < CH_NUM; c++) begin
                if (wr_ok && reg_hit && blk == cfg_addr_t'(c)) begin
                    case (off)
                        REG_SRC: src_q[c] <= {pwdata[ADDR_W-1:2], 2'b00};   // Word aligned
                        REG_DST: dst_q[c] <= {pwdata[ADDR_W-1:2], 2'b00};
                        REG_LEN: len_q[c] <= pwdata[LEN_W-1:0];
                        default: begin
                            start_q[c] <= pwdata[CTRL_START_BIT];
                            trig_q[c]  <= pwdata[CTRL_TRIG_BIT];
                            busy_q[c]  <= pwdata[CTRL_START_BIT];
                        end
                    endcase
                end
                if (ch_start[c]) begin
                    start_q[c] <= 1'b0;    // Handed to the mover
                end
                if (ch_end[c]) begin
                    busy_q[c] <= 1'b0;
                end
            end
            // Completion sets win over a same-cycle clear
            done_q <= (done_q & ~done_clr) | (ch_end & {CH_NUM{~end_err}});
            err_q  <= (err_q & ~err_clr) | (ch_end & {CH_NUM{end_err}});
        end
    end

    assign ch_run   = start_q & (~trig_q | req_pending);
    assign ch_src   = src_q;
    assign ch_dst   = dst_q;
    assign ch_len   = len_q;
    assign dma_done = done_q;
    assign dma_err  = |err_q;

    // Checks --------------------
    // Mover grants only channels that asked to run
    a_start_run: assert property (@(posedge clk) disable iff (!arst_n)
        (ch_start & ~ch_run) == '0);

endmodule

// ==== verilog/dma_pkg.sv ====
// DMA controller shared widths, register map, status layout and AHB codes
package dma_pkg;

    // Widths --------------------
    localparam int ADDR_W     = 32;   // System address
    localparam int DATA_W     = 32;
    localparam int CFG_ADDR_W = 8;    // APB address
    localparam int LEN_W      = 16;   // Word count

    // Channels --------------------
    localparam int CH_NUM   = 2;
    localparam int CH_IDX_W = (CH_NUM > 1) ? $clog2(CH_NUM) : 1;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

    // Register map --------------------
    // Byte offsets inside one channel block
    localparam cfg_addr_t REG_SRC  = 'h00;
    localparam cfg_addr_t REG_DST  = 'h04;
    localparam cfg_addr_t REG_LEN  = 'h08;
    localparam cfg_addr_t REG_CTRL = 'h0C;

    localparam cfg_addr_t CH_STRIDE  = 'h10;   // Channel block spacing
    localparam cfg_addr_t REG_STATUS = 'h40;   // Global status

    // Control word bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_TRIG_BIT  = 1;

    // Status word fields, one bit per channel
    localparam int STAT_DONE_LSB = 0;
    localparam int STAT_ERR_LSB  = 2;
    localparam int STAT_BUSY_LSB = 4;

    // AHB transfer codes --------------------
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

endpackage

// ==== verilog/dma_req_sync.sv ====
// DMA request synchronizer with rising edge detect and held pending flag
`timescale 1ns/1ns

module dma_req_sync (
    input  logic clk,
    input  logic arst_n,
    input  logic dma_req,       // Asynchronous request line
    input  logic ch_start,      // Channel granted by the mover
    output logic req_pending
);

    logic req_meta;   // First synchronizer stage
    logic req_sync;
    logic req_prev;   // Edge register
    logic req_rise;

    assign req_rise = req_sync & ~req_prev;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_meta    <= 1'b0;
            req_sync    <= 1'b0;
            req_prev    <= 1'b0;
            req_pending <= 1'b0;
        end else begin
            req_meta <= dma_req;
            req_sync <= req_meta;
            req_prev <= req_sync;
            // A start consumes the request, extra edges fold into it
            if (ch_start) begin
                req_pending <= 1'b0;
            end else if (req_rise) begin
                req_pending <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/dma_top.sv ====
// Two-channel memory-to-memory DMA with APB configuration and AHB-Lite master
`timescale 1ns/1ns

module dma_top (
    input  logic                         clk,
    input  logic                         arst_n,

    // APB configuration port
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  dma_pkg::cfg_addr_t           paddr,
    input  dma_pkg::data_t               pwdata,
    output dma_pkg::data_t               prdata,
    output logic                         pready,
    output logic                         pslverr,

    // AHB-Lite master port
    output dma_pkg::addr_t               haddr,
    output logic [1:0]                   htrans,
    output logic                         hwrite,
    output dma_pkg::data_t               hwdata,
    input  dma_pkg::data_t               hrdata,
    input  logic                         hready,
    input  logic                         hresp,

    // Requests and status
    input  logic [dma_pkg::CH_NUM-1:0]   dma_req,
    output logic [dma_pkg::CH_NUM-1:0]   dma_done,
    output logic                         dma_err
);
    import dma_pkg::*;

    logic [CH_NUM-1:0] req_pending;
    logic [CH_NUM-1:0] ch_run;
    logic [CH_NUM-1:0] ch_start;    // Grant pulse from the mover
    logic [CH_NUM-1:0] ch_end;
    logic              end_err;
    addr_t             ch_src [CH_NUM];
    addr_t             ch_dst [CH_NUM];
    len_t              ch_len [CH_NUM];

    dma_apb_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .req_pending (req_pending),
        .ch_start    (ch_start),
        .ch_end      (ch_end),
        .end_err     (end_err),
        .ch_run      (ch_run),
        .ch_src      (ch_src),
        .ch_dst      (ch_dst),
        .ch_len      (ch_len),
        .dma_done    (dma_done),
        .dma_err     (dma_err)
    );

    // One request synchronizer per channel
    for (genvar c = 0; c < CH_NUM; c++) begin : g_req_sync
        dma_req_sync u_req_sync (
            .clk         (clk),
            .arst_n      (arst_n),
            .dma_req     (dma_req[c]),
            .ch_start    (ch_start[c]),
            .req_pending (req_pending[c])
        );
    end

    dma_ahb_mover u_mover (
        .clk      (clk),
        .arst_n   (arst_n),
        .ch_run   (ch_run),
        .ch_src   (ch_src),
        .ch_dst   (ch_dst),
        .ch_len   (ch_len),
        .ch_start (ch_start),
        .ch_end   (ch_end),
        .end_err  (end_err),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp)
    );

endmodule
